// File: hdl/fpu_rnd_pkg.sv
`default_nettype none

package fpu_rnd_pkg;

  ////////////////////
  // widths
  ////////////////////

  // fraction from the sources: headroom, 24-bit significand, round, sticky
  localparam int FRACT_W = 27;
  // significand as carried between stages, with carry headroom
  localparam int SIG_W   = FRACT_W - 2;
  // working exponent, room above 254 for overflow
  localparam int EXP_W   = 10;
  localparam int FLAG_W  = 5;

  typedef logic [FRACT_W-1:0] fract_t;
  typedef logic [EXP_W-1:0]   exp_t;
  typedef logic [4:0]         shamt_t;
  typedef logic [31:0]        sp_word_t;

  ////////////////////
  // format constants
  ////////////////////

  // largest finite biased exponent
  localparam exp_t        EXP_MAX_S = 10'd254;
  // infinity magnitude, sign excluded
  localparam logic [30:0] INF_S     = 31'h7f80_0000;

  ////////////////////
  // types
  ////////////////////

  typedef enum logic [1:0] {
    RM_NEAREST = 2'd0,
    RM_TO_ZERO = 2'd1,
    RM_TO_INFP = 2'd2,
    RM_TO_INFM = 2'd3
  } rnd_mode_t;

  // one request from the adder or the multiplier
  typedef struct packed {
    logic   sign;
    // exact zero from a subtraction
    logic   sub_zero;
    shamt_t shr;
    shamt_t shl;
    exp_t   exp_shr;
    exp_t   exp_shl;
    exp_t   exp_sh0;
    fract_t fract;
  } rnd_req_t;

  typedef struct packed {
    logic ine;
    logic ovf;
    logic inf;
    logic unf;
    logic zer;
  } rnd_flags_t;

  // write-back port took the result or not
  typedef enum logic {
    WB_LIVE = 1'b0,
    WB_MISS = 1'b1
  } wb_state_t;

  // item between stages
  typedef struct packed {
    logic             sign;
    exp_t             exp;
    logic [SIG_W-1:0] fract;
    logic             round;
    logic             sticky;
    logic             lost;
  } stage_t;

endpackage

`default_nettype wire

// File: hdl/fpu_rnd_align.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_rnd_align import fpu_rnd_pkg::*; (
  input  wire            cpu_clk,
  input  wire            add_rdy_i,
  input  wire rnd_req_t  add_req_i,
  input  wire            mul_rdy_i,
  input  wire rnd_req_t  mul_req_i,
  input  wire rnd_mode_t rnd_mode_i,
  input  wire            s0_adv_i,
  input  wire            s1_adv_i,
  output stage_t         s1_o
);

  ////////////////////
  // stage 0: source mux
  ////////////////////

  rnd_req_t s0_req;
  logic     s0_sign_sel;
  exp_t     s0_exp_sel;

  // at most one source is ready, so and-or is enough
  assign s0_req = ({$bits(rnd_req_t){add_rdy_i}} & add_req_i) |
                  ({$bits(rnd_req_t){mul_rdy_i}} & mul_req_i);

  // exact zero difference: minus only when rounding down
  assign s0_sign_sel = s0_req.sub_zero ? (rnd_mode_i == RM_TO_INFM) : s0_req.sign;

  // exponent follows the shift direction
  assign s0_exp_sel = (|s0_req.shr) ? s0_req.exp_shr :
                      (|s0_req.shl) ? s0_req.exp_shl :
                                      s0_req.exp_sh0;

  logic   s0_sign;
  shamt_t s0_shr;
  shamt_t s0_shl;
  exp_t   s0_exp;
  fract_t s0_fract;

  always_ff @(posedge cpu_clk) begin
    if (s0_adv_i) begin
      s0_sign  <= s0_sign_sel;
      s0_shr   <= s0_req.shr;
      s0_shl   <= s0_req.shl;
      s0_exp   <= s0_exp_sel;
      s0_fract <= s0_req.fract;
    end
  end

  ////////////////////
  // stage 1: align
  ////////////////////

  fract_t             shr_val;
  fract_t             shl_val;
  fract_t             sh_val;
  logic [FRACT_W-1:0] out_mask;
  logic               s1_is_shr;
  logic               s1_sticky;
  stage_t             s1_next;

  assign shr_val   = s0_fract >> s0_shr;
  assign shl_val   = s0_fract << s0_shl;
  assign s1_is_shr = |s0_shr;
  assign sh_val    = s1_is_shr ? shr_val : shl_val;

  // bits that fall off the bottom on a right shift
  assign out_mask = ~({FRACT_W{1'b1}} << s0_shr);

  // left shift fills with zeros, so sticky survives only at shl == 0
  assign s1_sticky = s1_is_shr ? ((|(s0_fract & out_mask)) | shr_val[0]) : shl_val[0];

  always_comb begin
    s1_next.sign   = s0_sign;
    s1_next.exp    = s0_exp;
    s1_next.fract  = sh_val[FRACT_W-1:2];
    s1_next.round  = sh_val[1];
    s1_next.sticky = s1_sticky;
    s1_next.lost   = sh_val[1] | s1_sticky;
  end

  always_ff @(posedge cpu_clk) begin
    if (s1_adv_i) begin
      s1_o <= s1_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/fpu_rnd_round.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_rnd_round import fpu_rnd_pkg::*; (
  input  wire            cpu_clk,
  input  wire stage_t    s1_i,
  input  wire rnd_mode_t rnd_mode_i,
  input  wire            s2_adv_i,
  input  wire            s3_adv_i,
  output stage_t         s3_o,
  output logic           s3_ovf_o,
  output logic           s3_denorm_o
);

  ////////////////////
  // stage 2: round
  ////////////////////

  logic   rnd_up;
  stage_t s2_next;
  stage_t s2_q;

  always_comb begin
    case (rnd_mode_i)
      // ties go to even
      RM_NEAREST: rnd_up = s1_i.round & (s1_i.sticky | s1_i.fract[0]);
      RM_TO_ZERO: rnd_up = 1'b0;
      RM_TO_INFP: rnd_up = ~s1_i.sign & s1_i.lost;
      RM_TO_INFM: rnd_up = s1_i.sign & s1_i.lost;
      default:    rnd_up = 1'b0;
    endcase
  end

  always_comb begin
    s2_next       = s1_i;
    // may carry into the headroom bit
    s2_next.fract = s1_i.fract + {{(SIG_W-1){1'b0}}, rnd_up};
  end

  always_ff @(posedge cpu_clk) begin
    if (s2_adv_i) begin
      s2_q <= s2_next;
    end
  end

  ////////////////////
  // stage 3: renormalize
  ////////////////////

  logic   rnd_carry;
  stage_t s3_next;
  logic   s3_ovf_next;
  logic   s3_denorm_next;

  assign rnd_carry = s2_q.fract[SIG_W-1];

  always_comb begin
    s3_next       = s2_q;
    // carry out of rounding: one step right, exponent up
    s3_next.fract = rnd_carry ? (s2_q.fract >> 1) : s2_q.fract;
    s3_next.exp   = s2_q.exp + {{(EXP_W-1){1'b0}}, rnd_carry};
  end

  assign s3_ovf_next    = s3_next.exp > EXP_MAX_S;
  // hidden bit clear, so denormal or zero
  assign s3_denorm_next = ~s3_next.fract[SIG_W-2];

  always_ff @(posedge cpu_clk) begin
    if (s3_adv_i) begin
      s3_o        <= s3_next;
      s3_ovf_o    <= s3_ovf_next;
      s3_denorm_o <= s3_denorm_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/fpu_rnd_format.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_rnd_format import fpu_rnd_pkg::*; (
  input  wire stage_t     s3_i,
  input  wire             s3_ovf_i,
  input  wire             s3_denorm_i,
  input  wire rnd_flags_t flag_mask_i,
  output sp_word_t        res_o,
  output rnd_flags_t      flags_o
);

  ////////////////////
  // result packing
  ////////////////////

  logic [22:0] frac23;
  logic        frac_zero;

  // drop the hidden bit
  assign frac23    = s3_i.fract[22:0];
  assign frac_zero = ~(|frac23);

  always_comb begin
    if (s3_ovf_i) begin
      // past the largest finite value
      res_o = {s3_i.sign, INF_S};
    end else if (s3_denorm_i) begin
      // denormal keeps a zero exponent field
      res_o = {s3_i.sign, 8'd0, frac23};
    end else begin
      res_o = {s3_i.sign, s3_i.exp[7:0], frac23};
    end
  end

  ////////////////////
  // flags
  ////////////////////

  rnd_flags_t flags_raw;

  always_comb begin
    // overflow is always inexact
    flags_raw.ine = s3_i.lost | s3_ovf_i;
    flags_raw.ovf = s3_ovf_i;
    flags_raw.inf = s3_ovf_i;
    // tiny and inexact
    flags_raw.unf = s3_denorm_i & s3_i.lost;
    flags_raw.zer = s3_denorm_i & frac_zero;
  end

  // masked per flag
  assign flags_o = flags_raw & flag_mask_i;

endmodule

`default_nettype wire

// File: hdl/fpu_rnd_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_rnd_pipe_ctrl import fpu_rnd_pkg::*; (
  input  wire             cpu_clk,
  input  wire             reset_i,
  input  wire             pipeline_flush_i,
  input  wire             add_rdy_i,
  input  wire             mul_rdy_i,
  input  wire             padv_wrbk_i,
  input  wire             grant_wrbk_i,
  input  wire             except_enable_i,
  input  wire sp_word_t   res_i,
  input  wire rnd_flags_t flags_i,
  output logic            rnd_taking_add_o,
  output logic            rnd_taking_mul_o,
  output logic            s0_adv_o,
  output logic            s1_adv_o,
  output logic            s2_adv_o,
  output logic            s3_adv_o,
  output logic            rnd_valid_o,
  output logic            exec_except_o,
  output sp_word_t        wrbk_res_o,
  output rnd_flags_t      wrbk_flags_o,
  output logic            wrbk_flags_we_o,
  output logic            wrbk_except_o
);

  ////////////////////
  // busy chain, advance
  ////////////////////

  logic      s0_rdy, s1_rdy, s2_rdy, s3_rdy;
  logic      s0_busy, s1_busy, s2_busy, s3_busy;
  wb_state_t wb_state;
  logic      wb_have;
  logic      wb_go;

  // stage 3 stalls only while the pending buffer is full
  assign s3_busy = s3_rdy & (wb_state == WB_MISS);
  assign s2_busy = s2_rdy & s3_busy;
  assign s1_busy = s1_rdy & s2_busy;
  assign s0_busy = s0_rdy & s1_busy;

  assign s0_adv_o = (add_rdy_i | mul_rdy_i) & ~s0_busy;
  assign s1_adv_o = s0_rdy & ~s1_busy;
  assign s2_adv_o = s1_rdy & ~s2_busy;
  assign s3_adv_o = s2_rdy & ~s3_busy;

  assign rnd_taking_add_o = add_rdy_i & ~s0_busy;
  assign rnd_taking_mul_o = mul_rdy_i & ~s0_busy;

  // a result sits in stage 3 or in the pending buffer
  assign wb_have = s3_rdy | (wb_state == WB_MISS);
  assign wb_go   = padv_wrbk_i & grant_wrbk_i & wb_have;

  always_ff @(posedge cpu_clk) begin
    if (reset_i | pipeline_flush_i) begin
      s0_rdy <= 1'b0;
      s1_rdy <= 1'b0;
      s2_rdy <= 1'b0;
      s3_rdy <= 1'b0;
    end else begin
      // filled on own advance, emptied on the next one
      if (s0_adv_o) s0_rdy <= 1'b1;
      else if (s1_adv_o) s0_rdy <= 1'b0;
      if (s1_adv_o) s1_rdy <= 1'b1;
      else if (s2_adv_o) s1_rdy <= 1'b0;
      if (s2_adv_o) s2_rdy <= 1'b1;
      else if (s3_adv_o) s2_rdy <= 1'b0;
      // live item leaves either to write-back or to pending
      if (s3_adv_o) s3_rdy <= 1'b1;
      else if (wb_state == WB_LIVE) s3_rdy <= 1'b0;
    end
  end

  ////////////////////
  // write-back miss FSM
  ////////////////////

  always_ff @(posedge cpu_clk) begin
    if (reset_i | pipeline_flush_i) begin
      wb_state <= WB_LIVE;
    end else begin
      case (wb_state)
        WB_LIVE: if (s3_rdy & ~wb_go) wb_state <= WB_MISS;
        WB_MISS: if (wb_go) wb_state <= WB_LIVE;
        default: wb_state <= WB_LIVE;
      endcase
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (reset_i | pipeline_flush_i) begin
      rnd_valid_o <= 1'b0;
    end else if (s3_adv_o) begin
      rnd_valid_o <= 1'b1;
    end else if (wb_go) begin
      // pending went out, a stage 3 item may still wait
      rnd_valid_o <= (wb_state == WB_MISS) & s3_rdy;
    end
  end

  // pending buffer tracks the live result until a miss
  sp_word_t   pend_res;
  rnd_flags_t pend_flags;

  always_ff @(posedge cpu_clk) begin
    if (wb_state == WB_LIVE) begin
      pend_res   <= res_i;
      pend_flags <= flags_i;
    end
  end

  ////////////////////
  // write-back outputs
  ////////////////////

  sp_word_t   wb_res_mux;
  rnd_flags_t wb_flags_mux;
  logic       wb_except_mux;

  assign wb_res_mux    = (wb_state == WB_MISS) ? pend_res : res_i;
  assign wb_flags_mux  = (wb_state == WB_MISS) ? pend_flags : flags_i;
  assign wb_except_mux = except_enable_i & (|wb_flags_mux);
  assign exec_except_o = grant_wrbk_i & wb_except_mux;

  always_ff @(posedge cpu_clk) begin
    if (padv_wrbk_i) begin
      wrbk_res_o <= wb_go ? wb_res_mux : '0;
    end
  end

  // flags and strobes last one cycle
  always_ff @(posedge cpu_clk) begin
    if (reset_i | pipeline_flush_i | ~wb_go) begin
      wrbk_flags_o    <= rnd_flags_t'({FLAG_W{1'b0}});
      wrbk_flags_we_o <= 1'b0;
      wrbk_except_o   <= 1'b0;
    end else begin
      wrbk_flags_o    <= wb_flags_mux;
      wrbk_flags_we_o <= 1'b1;
      wrbk_except_o   <= wb_except_mux;
    end
  end

endmodule

`default_nettype wire

// File: hdl/fpu_rnd_top.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_rnd_top import fpu_rnd_pkg::*; (
  input  wire             cpu_clk,
  input  wire             reset_i,
  input  wire             pipeline_flush_i,
  input  wire             add_rdy_i,
  input  wire rnd_req_t   add_req_i,
  input  wire             mul_rdy_i,
  input  wire rnd_req_t   mul_req_i,
  input  wire rnd_mode_t  rnd_mode_i,
  input  wire rnd_flags_t flag_mask_i,
  input  wire             except_enable_i,
  input  wire             padv_wrbk_i,
  input  wire             grant_wrbk_i,
  output logic            rnd_taking_add_o,
  output logic            rnd_taking_mul_o,
  output logic            rnd_valid_o,
  output logic            exec_except_o,
  output sp_word_t        wrbk_res_o,
  output rnd_flags_t      wrbk_flags_o,
  output logic            wrbk_flags_we_o,
  output logic            wrbk_except_o
);

  // advance strobes
  logic       s0_adv, s1_adv, s2_adv, s3_adv;
  // datapath between stages
  stage_t     s1;
  stage_t     s3;
  logic       s3_ovf;
  logic       s3_denorm;
  // formatted live result
  sp_word_t   fmt_res;
  rnd_flags_t fmt_flags;

  ////////////////////
  // datapath
  ////////////////////

  fpu_rnd_align fpu_rnd_align_i (
    .cpu_clk    (cpu_clk),
    .add_rdy_i  (add_rdy_i),
    .add_req_i  (add_req_i),
    .mul_rdy_i  (mul_rdy_i),
    .mul_req_i  (mul_req_i),
    .rnd_mode_i (rnd_mode_i),
    .s0_adv_i   (s0_adv),
    .s1_adv_i   (s1_adv),
    .s1_o       (s1)
  );

  fpu_rnd_round fpu_rnd_round_i (
    .cpu_clk     (cpu_clk),
    .s1_i        (s1),
    .rnd_mode_i  (rnd_mode_i),
    .s2_adv_i    (s2_adv),
    .s3_adv_i    (s3_adv),
    .s3_o        (s3),
    .s3_ovf_o    (s3_ovf),
    .s3_denorm_o (s3_denorm)
  );

  fpu_rnd_format fpu_rnd_format_i (
    .s3_i        (s3),
    .s3_ovf_i    (s3_ovf),
    .s3_denorm_i (s3_denorm),
    .flag_mask_i (flag_mask_i),
    .res_o       (fmt_res),
    .flags_o     (fmt_flags)
  );

  ////////////////////
  // control
  ////////////////////

  fpu_rnd_pipe_ctrl fpu_rnd_pipe_ctrl_i (
    .cpu_clk          (cpu_clk),
    .reset_i          (reset_i),
    .pipeline_flush_i (pipeline_flush_i),
    .add_rdy_i        (add_rdy_i),
    .mul_rdy_i        (mul_rdy_i),
    .padv_wrbk_i      (padv_wrbk_i),
    .grant_wrbk_i     (grant_wrbk_i),
    .except_enable_i  (except_enable_i),
    .res_i            (fmt_res),
    .flags_i          (fmt_flags),
    .rnd_taking_add_o (rnd_taking_add_o),
    .rnd_taking_mul_o (rnd_taking_mul_o),
    .s0_adv_o         (s0_adv),
    .s1_adv_o         (s1_adv),
    .s2_adv_o         (s2_adv),
    .s3_adv_o         (s3_adv),
    .rnd_valid_o      (rnd_valid_o),
    .exec_except_o    (exec_except_o),
    .wrbk_res_o       (wrbk_res_o),
    .wrbk_flags_o     (wrbk_flags_o),
    .wrbk_flags_we_o  (wrbk_flags_we_o),
    .wrbk_except_o    (wrbk_except_o)
  );

endmodule

`default_nettype wire

// File: dv/fpu_rnd_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fpu_rnd_tb import fpu_rnd_pkg::*; ();

  // roughly the number of requests over all tests
  localparam int N_REQ      = 260;
  localparam int MAX_CYCLES = 50 * N_REQ + 200;

  typedef struct packed {
    sp_word_t   res;
    rnd_flags_t flags;
    logic       except;
  } expect_t;

  logic       cpu_clk          = 1'b0;
  logic       reset_i          = 1'b1;
  logic       pipeline_flush_i = 1'b0;
  logic       add_rdy_i        = 1'b0;
  rnd_req_t   add_req_i        = '0;
  logic       mul_rdy_i        = 1'b0;
  rnd_req_t   mul_req_i        = '0;
  rnd_mode_t  rnd_mode_i       = RM_NEAREST;
  rnd_flags_t flag_mask_i      = '1;
  logic       except_enable_i  = 1'b0;
  logic       padv_wrbk_i      = 1'b0;
  logic       grant_wrbk_i     = 1'b0;
  logic       rnd_taking_add_o;
  logic       rnd_taking_mul_o;
  logic       rnd_valid_o;
  logic       exec_except_o;
  sp_word_t   wrbk_res_o;
  rnd_flags_t wrbk_flags_o;
  logic       wrbk_flags_we_o;
  logic       wrbk_except_o;

  // write-back port: grant level or random
  logic    grant_set = 1'b1;
  logic    wb_random = 1'b0;
  integer  seed      = 32'h7db8_0462;
  int      checks    = 0;
  int      errors    = 0;
  int      checks0   = 0;
  int      errors0   = 0;
  int      cycle_cnt = 0;
  string   cur_test  = "reset";
  expect_t exp_q[$];
  expect_t last_exp  = '0;

  always #2 cpu_clk = ~cpu_clk;

  fpu_rnd_top fpu_rnd_top_i (
    .cpu_clk          (cpu_clk),
    .reset_i          (reset_i),
    .pipeline_flush_i (pipeline_flush_i),
    .add_rdy_i        (add_rdy_i),
    .add_req_i        (add_req_i),
    .mul_rdy_i        (mul_rdy_i),
    .mul_req_i        (mul_req_i),
    .rnd_mode_i       (rnd_mode_i),
    .flag_mask_i      (flag_mask_i),
    .except_enable_i  (except_enable_i),
    .padv_wrbk_i      (padv_wrbk_i),
    .grant_wrbk_i     (grant_wrbk_i),
    .rnd_taking_add_o (rnd_taking_add_o),
    .rnd_taking_mul_o (rnd_taking_mul_o),
    .rnd_valid_o      (rnd_valid_o),
    .exec_except_o    (exec_except_o),
    .wrbk_res_o       (wrbk_res_o),
    .wrbk_flags_o     (wrbk_flags_o),
    .wrbk_flags_we_o  (wrbk_flags_we_o),
    .wrbk_except_o    (wrbk_except_o)
  );

  ////////////////////
  // reference model
  ////////////////////

  function automatic expect_t rnd_ref(input rnd_req_t r, input rnd_mode_t m,
                                      input rnd_flags_t mask);
    logic [53:0] wide;
    logic [26:0] al;
    logic [24:0] sig;
    logic [10:0] e;
    logic        sgn, rbit, sbit, lost, up, ovf, den;
    expect_t     x;
    // exact zero takes its sign from the mode
    sgn = r.sub_zero ? (m == RM_TO_INFM) : r.sign;
    if (r.shr != 5'd0) begin
      // keep everything that falls off in the low half
      wide = {r.fract, 27'd0} >> r.shr;
      al   = wide[53:27];
      sbit = al[0] | (|wide[26:0]);
      e    = {1'b0, r.exp_shr};
    end else begin
      al   = r.fract << r.shl;
      sbit = al[0];
      e    = (r.shl != 5'd0) ? {1'b0, r.exp_shl} : {1'b0, r.exp_sh0};
    end
    rbit = al[1];
    lost = rbit | sbit;
    sig  = al[26:2];
    case (m)
      RM_NEAREST: up = rbit & (sbit | sig[0]);
      RM_TO_INFP: up = ~sgn & lost;
      RM_TO_INFM: up = sgn & lost;
      default:    up = 1'b0;
    endcase
    sig = sig + {24'd0, up};
    // carry past the hidden bit
    if (sig[24]) begin
      sig = sig >> 1;
      e   = e + 11'd1;
    end
    ovf = e > 11'd254;
    den = ~sig[23];
    if (ovf) x.res = {sgn, 8'hff, 23'd0};
    else if (den) x.res = {sgn, 8'h00, sig[22:0]};
    else x.res = {sgn, e[7:0], sig[22:0]};
    x.flags.ine = lost | ovf;
    x.flags.ovf = ovf;
    x.flags.inf = ovf;
    x.flags.unf = den & lost;
    x.flags.zer = den & (sig[22:0] == 23'd0);
    x.flags     = x.flags & mask;
    x.except    = 1'b0;
    return x;
  endfunction

  task automatic check(input string what, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    checks++;
    if (exp_val !== act_val) begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", cur_test, what, exp_val, act_val);
    end
  endtask

  ////////////////////
  // scoreboard
  ////////////////////

  // negedge: taking and write-back outputs settled
  always @(negedge cpu_clk) begin
    expect_t want;
    expect_t got;
    if (wrbk_flags_we_o) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("%s: write-back strobe with no result outstanding", cur_test);
      end else begin
        want = exp_q.pop_front();
        check("result", want.res, wrbk_res_o);
        check("flags", {27'd0, want.flags}, {27'd0, wrbk_flags_o});
        check("except", {31'd0, want.except}, {31'd0, wrbk_except_o});
      end
    end
    if (rnd_taking_add_o | rnd_taking_mul_o) begin
      got = rnd_ref(rnd_taking_mul_o ? mul_req_i : add_req_i, rnd_mode_i, flag_mask_i);
      got.except = except_enable_i & (|got.flags);
      exp_q.push_back(got);
      last_exp = got;
    end
  end

  // write-back port driver
  always @(posedge cpu_clk) begin
    logic [31:0] rv;
    if (wb_random) begin
      rv = $random(seed);
      padv_wrbk_i  <= rv[0];
      grant_wrbk_i <= rv[1];
    end else begin
      padv_wrbk_i  <= 1'b1;
      grant_wrbk_i <= grant_set;
    end
  end

  ////////////////////
  // stimulus helpers
  ////////////////////

  function automatic rnd_req_t mk(input logic sgn, input logic sz, input shamt_t shr,
                                  input shamt_t shl, input exp_t e, input fract_t f);
    rnd_req_t r;
    r.sign     = sgn;
    r.sub_zero = sz;
    r.shr      = shr;
    r.shl      = shl;
    r.exp_shr  = e;
    r.exp_shl  = e;
    r.exp_sh0  = e;
    r.fract    = f;
    return r;
  endfunction

  task automatic gen_req(output logic src_mul, output rnd_req_t r);
    logic [31:0] rv;
    logic [31:0] rf;
    logic [31:0] re;
    rv = $random(seed);
    rf = $random(seed);
    re = $random(seed);
    src_mul    = rv[0];
    r.sign     = rv[1];
    r.sub_zero = (rv[6:2] == 5'd0);
    r.shr      = 5'd0;
    r.shl      = 5'd0;
    r.exp_shr  = {2'b00, re[7:0]};
    // multiplier never shifts left
    r.exp_shl  = rv[0] ? 10'd0 : {2'b00, re[15:8]};
    r.exp_sh0  = {2'b00, re[23:16]};
    // headroom bit clear on entry
    r.fract    = {1'b0, rf[25:0]};
    case (rv[8:7])
      2'd0: r.shr = 5'd0;
      2'd1: r.shr = (rv[13:9] == 5'd0) ? 5'd1 : rv[13:9];
      2'd2: r.shr = {3'b000, rv[10:9]} + 5'd1;
      2'd3: begin
        if (!rv[0]) begin
          r.shl   = {2'b00, rv[11:9]} + 5'd1;
          r.fract = r.fract >> r.shl;
        end
      end
    endcase
    if (r.sub_zero) r.fract = '0;
  endtask

  // present one request, return once it is taken
  task automatic send(input logic src_mul, input rnd_req_t req);
    @(posedge cpu_clk);
    add_rdy_i <= ~src_mul;
    mul_rdy_i <= src_mul;
    add_req_i <= src_mul ? ~req : req;
    mul_req_i <= src_mul ? req : ~req;
    do @(negedge cpu_clk); while (!(rnd_taking_add_o | rnd_taking_mul_o));
  endtask

  task automatic idle();
    @(posedge cpu_clk);
    add_rdy_i <= 1'b0;
    mul_rdy_i <= 1'b0;
  endtask

  task automatic drain();
    do @(posedge cpu_clk); while (exp_q.size() != 0);
  endtask

  task automatic set_cfg(input rnd_mode_t m, input rnd_flags_t mask, input logic en);
    @(posedge cpu_clk);
    rnd_mode_i      <= m;
    flag_mask_i     <= mask;
    except_enable_i <= en;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    checks0  = checks;
    errors0  = errors;
  endtask

  task automatic end_test();
    $display("test %-10s done: %0d checks, %0d errors", cur_test,
             checks - checks0, errors - errors0);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    rnd_req_t    req;
    logic        src;
    logic [31:0] rv;
    rnd_mode_t   m;
    rnd_flags_t  masks[4];
    logic        ens[4];
    masks = '{5'b11111, 5'b01111, 5'b00000, 5'b11111};
    ens   = '{1'b1, 1'b1, 1'b1, 1'b0};
    repeat (10) @(posedge cpu_clk);
    reset_i <= 1'b0;

    // ties and near ties, hidden bit at 25
    start_test("ties");
    set_cfg(RM_NEAREST, '1, 1'b0);
    send(1'b0, mk(1'b0, 1'b0, 5'd0, 5'd0, 10'd127, 27'h200_0002));
    send(1'b0, mk(1'b0, 1'b0, 5'd0, 5'd0, 10'd127, 27'h200_0006));
    send(1'b0, mk(1'b0, 1'b0, 5'd0, 5'd0, 10'd127, 27'h200_0004));
    send(1'b0, mk(1'b1, 1'b0, 5'd0, 5'd0, 10'd127, 27'h200_0003));
    send(1'b0, mk(1'b0, 1'b0, 5'd0, 5'd0, 10'd127, 27'h200_0001));
    send(1'b1, mk(1'b1, 1'b0, 5'd1, 5'd0, 10'd130, 27'h400_0004));
    idle();
    drain();
    end_test();

    // every mode, both signs, rounding carry, exact zero
    start_test("modes");
    for (int i = 0; i < 4; i++) begin
      m = rnd_mode_t'(i[1:0]);
      set_cfg(m, '1, 1'b0);
      send(1'b0, mk(1'b0, 1'b0, 5'd0, 5'd0, 10'd127, 27'h200_0001));
      send(1'b0, mk(1'b1, 1'b0, 5'd0, 5'd0, 10'd127, 27'h200_0001));
      send(1'b1, mk(1'b0, 1'b0, 5'd0, 5'd0, 10'd100, 27'h3ff_ffff));
      send(1'b1, mk(1'b1, 1'b0, 5'd0, 5'd0, 10'd100, 27'h3ff_ffff));
      send(1'b0, mk(1'b0, 1'b1, 5'd0, 5'd0, 10'd0, 27'h000_0000));
      send(1'b0, mk(1'b1, 1'b1, 5'd0, 5'd0, 10'd0, 27'h000_0000));
      idle();
      drain();
    end
    end_test();

    // overflow under several masks, last item always overflows
    start_test("overflow");
    for (int i = 0; i < 4; i++) begin
      set_cfg(RM_NEAREST, masks[i], ens[i]);
      send(1'b0, mk(1'b0, 1'b0, 5'd0, 5'd0, 10'd254, 27'h200_0004));
      send(1'b0, mk(1'b1, 1'b0, 5'd0, 5'd0, 10'd254, 27'h3ff_ffff));
      send(1'b1, mk(1'b0, 1'b0, 5'd0, 5'd0, 10'd255, 27'h200_0004));
      idle();
      drain();
      // stage 3 still holds the last result
      @(negedge cpu_clk);
      check("exec_except", {31'd0, last_exp.except}, {31'd0, exec_except_o});
    end
    end_test();

    // denormal and zero results
    start_test("denormal");
    set_cfg(RM_NEAREST, '1, 1'b0);
    send(1'b0, mk(1'b0, 1'b0, 5'd3, 5'd0, 10'd1, 27'h200_0000));
    send(1'b0, mk(1'b1, 1'b0, 5'd4, 5'd0, 10'd1, 27'h200_0001));
    send(1'b0, mk(1'b0, 1'b0, 5'd0, 5'd1, 10'd0, 27'h000_0404));
    send(1'b0, mk(1'b0, 1'b0, 5'd0, 5'd0, 10'd0, 27'h000_0005));
    send(1'b0, mk(1'b0, 1'b0, 5'd0, 5'd0, 10'd0, 27'h000_0000));
    send(1'b1, mk(1'b0, 1'b0, 5'd0, 5'd0, 10'd0, 27'h000_0001));
    idle();
    drain();
    set_cfg(RM_TO_INFP, '1, 1'b0);
    send(1'b1, mk(1'b0, 1'b0, 5'd0, 5'd0, 10'd0, 27'h000_0001));
    send(1'b0, mk(1'b0, 1'b0, 5'd24, 5'd0, 10'd1, 27'h300_0000));
    idle();
    drain();
    end_test();

    // random traffic, random write-back grants
    start_test("backpress");
    wb_random = 1'b1;
    for (int g = 0; g < 4; g++) begin
      set_cfg(rnd_mode_t'(g[1:0]), '1, 1'b1);
      for (int n = 0; n < 50; n++) begin
        gen_req(src, req);
        send(src, req);
        rv = $random(seed);
        if (rv[1:0] == 2'd0) idle();
      end
      idle();
      drain();
    end
    wb_random = 1'b0;
    end_test();

    // flush with items stuck behind a missing grant
    start_test("flush");
    grant_set = 1'b0;
    set_cfg(RM_NEAREST, '1, 1'b0);
    for (int n = 0; n < 4; n++) begin
      gen_req(src, req);
      send(src, req);
    end
    idle();
    @(posedge cpu_clk);
    pipeline_flush_i <= 1'b1;
    @(posedge cpu_clk);
    pipeline_flush_i <= 1'b0;
    @(negedge cpu_clk);
    exp_q.delete();
    check("valid", 32'd0, {31'd0, rnd_valid_o});
    grant_set = 1'b1;
    repeat (8) begin
      @(negedge cpu_clk);
      check("stray write-back", 32'd0, {31'd0, wrbk_flags_we_o});
      // write-back strobe without a result clears the word
      check("cleared result", 32'd0, wrbk_res_o);
    end
    for (int n = 0; n < 4; n++) begin
      gen_req(src, req);
      send(src, req);
    end
    idle();
    drain();
    end_test();

    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d results never came out", exp_q.size());
    end
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // run limit
  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge cpu_clk);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles in test %s", cycle_cnt, cur_test);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
hdl/fpu_rnd_pkg.sv
hdl/fpu_rnd_align.sv
hdl/fpu_rnd_round.sv
hdl/fpu_rnd_format.sv
hdl/fpu_rnd_pipe_ctrl.sv
hdl/fpu_rnd_top.sv
dv/fpu_rnd_tb.sv

// File: Makefile
TOP = fpu_rnd_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
